// ==== hdl/vcache_pkg.sv ====
// ====================
// vcache tile shared definitions
// address split, op codes and payload structs
// ====================
package vcache_pkg;

  // word addressed, 32-bit words
  localparam int addr_width_lp   = 12;
  localparam int data_width_lp   = 32;
  localparam int mask_width_lp   = data_width_lp / 8;

  // direct-mapped geometry
  localparam int block_words_lp  = 4;
  localparam int sets_lp         = 16;
  localparam int offset_width_lp = $clog2(block_words_lp);
  localparam int index_width_lp  = $clog2(sets_lp);
  localparam int tag_width_lp    = addr_width_lp - index_width_lp - offset_width_lp;
  localparam int block_addr_width_lp = addr_width_lp - offset_width_lp;

  localparam int cord_width_lp   = 4;
  localparam int tag_id_width_lp = 4;
  localparam int req_fifo_els_lp = 4;

  typedef enum logic [1:0] {
    op_load    = 2'b00,
    op_store   = 2'b01,
    op_amo_add = 2'b10
  } cache_op_e;

  // 54 bits
  typedef struct packed {
    cache_op_e                  op;
    logic [addr_width_lp-1:0]   addr;
    logic [data_width_lp-1:0]   data;
    logic [mask_width_lp-1:0]   mask;
    logic [tag_id_width_lp-1:0] id;
  } cache_req_s;

  // 37 bits
  typedef struct packed {
    logic [data_width_lp-1:0]   data;
    logic [tag_id_width_lp-1:0] id;
    logic                       store_ack;
  } cache_resp_s;

endpackage

// ==== hdl/vcache_fifo.sv ====
// ====================
// small circular FIFO
// payload type set per instance
// ====================
`timescale 1ns/1ns

module vcache_fifo #(
  parameter type payload_t = logic [7:0]
  , parameter int els_p = 4
) (
  input clk_i
  , input rst_n_i

  , input  logic     v_i
  , output logic     ready_o
  , input  payload_t data_i

  , output logic     v_o
  , input  logic     yumi_i
  , output payload_t data_o
);

  payload_t mem_r [els_p];

  logic [$clog2(els_p)-1:0]   rd_ptr_r;
  logic [$clog2(els_p)-1:0]   wr_ptr_r;
  logic [$clog2(els_p+1)-1:0] count_r;
  logic [$clog2(els_p+1)-1:0] count_n;
  logic ready_r;
  logic enq;
  logic deq;

  assign enq     = v_i & ready_r;
  assign deq     = yumi_i & v_o;
  assign ready_o = ready_r;
  assign v_o     = (count_r != '0);
  assign data_o  = mem_r[rd_ptr_r];

  always_comb begin
    count_n = count_r;
    if (enq && !deq) begin
      count_n = count_r + 1'b1;
    end else if (deq && !enq) begin
      count_n = count_r - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (enq) begin
      mem_r[wr_ptr_r] <= data_i;
    end
  end

  // ready is registered, so it stays low one cycle past reset
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rd_ptr_r <= '0;
      wr_ptr_r <= '0;
      count_r  <= '0;
      ready_r  <= 1'b0;
    end else begin
      count_r <= count_n;
      ready_r <= (count_n != ($clog2(els_p+1))'(els_p));
      if (enq) begin
        wr_ptr_r <= (wr_ptr_r == ($clog2(els_p))'(els_p-1)) ? '0 : wr_ptr_r + 1'b1;
      end
      if (deq) begin
        rd_ptr_r <= (rd_ptr_r == ($clog2(els_p))'(els_p-1)) ? '0 : rd_ptr_r + 1'b1;
      end
    end
  end

endmodule

// ==== hdl/link_to_cache.sv ====
// ====================
// core port to cache adapter
// request/response FIFOs, response tagging
// ====================
`timescale 1ns/1ns

module link_to_cache
  import vcache_pkg::*;
(
  input clk_i
  , input rst_n_i

  , input  logic                       req_v_i
  , output logic                       req_ready_o
  , input  cache_op_e                  req_op_i
  , input  logic [addr_width_lp-1:0]   req_addr_i
  , input  logic [data_width_lp-1:0]   req_data_i
  , input  logic [mask_width_lp-1:0]   req_mask_i
  , input  logic [tag_id_width_lp-1:0] req_id_i

  , output logic                       resp_v_o
  , input  logic                       resp_ready_i
  , output logic [data_width_lp-1:0]   resp_data_o
  , output logic [tag_id_width_lp-1:0] resp_id_o
  , output logic                       resp_store_ack_o

  , output logic                       pkt_v_o
  , input  logic                       pkt_yumi_i
  , output cache_op_e                  pkt_op_o
  , output logic [addr_width_lp-1:0]   pkt_addr_o
  , output logic [data_width_lp-1:0]   pkt_data_o
  , output logic [mask_width_lp-1:0]   pkt_mask_o

  , input  logic                       result_v_i
  , input  logic [data_width_lp-1:0]   result_data_i
  , output logic                       result_yumi_o
);

  cache_req_s  req_in;
  cache_req_s  req_head;
  cache_resp_s resp_in;
  cache_resp_s resp_head;
  logic req_head_v;
  logic resp_fifo_ready;

  // id and kind of the packet the cache is working on
  logic [tag_id_width_lp-1:0] id_r;
  logic store_r;

  assign req_in.op   = req_op_i;
  assign req_in.addr = req_addr_i;
  assign req_in.data = req_data_i;
  assign req_in.mask = req_mask_i;
  assign req_in.id   = req_id_i;

  vcache_fifo #(
    .payload_t(cache_req_s)
    ,.els_p(req_fifo_els_lp)
  ) req_fifo (
    .clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.v_i(req_v_i)
    ,.ready_o(req_ready_o)
    ,.data_i(req_in)
    ,.v_o(req_head_v)
    ,.yumi_i(pkt_yumi_i)
    ,.data_o(req_head)
  );

  // only offer a packet when its answer is sure to fit
  assign pkt_v_o    = req_head_v & resp_fifo_ready;
  assign pkt_op_o   = req_head.op;
  assign pkt_addr_o = req_head.addr;
  assign pkt_data_o = req_head.data;
  assign pkt_mask_o = req_head.mask;

  always_ff @(posedge clk_i) begin
    if (pkt_yumi_i) begin
      id_r    <= req_head.id;
      store_r <= (req_head.op == op_store);
    end
  end

  // stores answer with zero data and the ack flag
  assign resp_in.data      = store_r ? '0 : result_data_i;
  assign resp_in.id        = id_r;
  assign resp_in.store_ack = store_r;
  assign result_yumi_o     = result_v_i & resp_fifo_ready;

  vcache_fifo #(
    .payload_t(cache_resp_s)
    ,.els_p(req_fifo_els_lp)
  ) resp_fifo (
    .clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.v_i(result_v_i)
    ,.ready_o(resp_fifo_ready)
    ,.data_i(resp_in)
    ,.v_o(resp_v_o)
    ,.yumi_i(resp_v_o & resp_ready_i)
    ,.data_o(resp_head)
  );

  assign resp_data_o      = resp_head.data;
  assign resp_id_o        = resp_head.id;
  assign resp_store_ack_o = resp_head.store_ack;

endmodule

// ==== hdl/vcache_core.sv ====
// ====================
// direct-mapped write-back cache
// blocking, one packet at a time, atomic add
// ====================
`timescale 1ns/1ns

module vcache_core
  import vcache_pkg::*;
(
  input clk_i
  , input rst_n_i

  , input  logic                           pkt_v_i
  , output logic                           pkt_yumi_o
  , input  cache_op_e                      pkt_op_i
  , input  logic [addr_width_lp-1:0]       pkt_addr_i
  , input  logic [data_width_lp-1:0]       pkt_data_i
  , input  logic [mask_width_lp-1:0]       pkt_mask_i
  , output logic                           result_v_o
  , output logic [data_width_lp-1:0]       result_data_o
  , input  logic                           result_yumi_i

  , output logic                           dma_req_v_o
  , output logic                           dma_write_o
  , output logic [block_addr_width_lp-1:0] dma_block_addr_o
  , input  logic                           dma_done_i
  , input  logic [offset_width_lp-1:0]     dma_word_idx_i
  , output logic [data_width_lp-1:0]       dma_wdata_o
  , input  logic                           dma_fill_v_i
  , input  logic [data_width_lp-1:0]       dma_fill_data_i
);

  typedef enum logic [2:0] {
    st_idle,
    st_lookup,
    st_evict,
    st_fill,
    st_result
  } state_e;

  state_e state_r;

  logic [sets_lp-1:0]      valid_r;
  logic [sets_lp-1:0]      dirty_r;
  logic [tag_width_lp-1:0] tag_r [sets_lp];
  logic [data_width_lp-1:0] data_r [sets_lp][block_words_lp];
  logic [data_width_lp-1:0] result_r;

  logic [tag_width_lp-1:0]    pkt_tag;
  logic [index_width_lp-1:0]  pkt_index;
  logic [offset_width_lp-1:0] pkt_offset;
  logic hit;
  logic [data_width_lp-1:0] old_word;
  logic [data_width_lp-1:0] store_word;
  logic [data_width_lp-1:0] new_word;

  // packet stays at the FIFO head until yumi, so the address is stable
  assign {pkt_tag, pkt_index, pkt_offset} = pkt_addr_i;

  assign hit      = valid_r[pkt_index] && (tag_r[pkt_index] == pkt_tag);
  assign old_word = data_r[pkt_index][pkt_offset];

  // byte merge under the mask
  always_comb begin
    store_word = old_word;
    for (int b = 0; b < mask_width_lp; b++) begin
      if (pkt_mask_i[b]) begin
        store_word[8*b +: 8] = pkt_data_i[8*b +: 8];
      end
    end
  end

  assign new_word = (pkt_op_i == op_amo_add) ? old_word + pkt_data_i : store_word;

  // accept only on a hit, misses refill first and retry
  assign pkt_yumi_o    = (state_r == st_lookup) & pkt_v_i & hit;
  assign result_v_o    = (state_r == st_result);
  assign result_data_o = result_r;

  assign dma_req_v_o = (state_r == st_evict) | (state_r == st_fill);
  assign dma_write_o = (state_r == st_evict);
  // victim block uses the stored tag
  assign dma_block_addr_o = (state_r == st_evict)
                          ? {tag_r[pkt_index], pkt_index}
                          : {pkt_tag, pkt_index};
  assign dma_wdata_o = data_r[pkt_index][dma_word_idx_i];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_r <= st_idle;
      valid_r <= '0;
      dirty_r <= '0;
    end else begin
      case (state_r)
        st_idle: begin
          if (pkt_v_i) begin
            state_r <= st_lookup;
          end
        end
        st_lookup: begin
          if (!pkt_v_i) begin
            state_r <= st_idle;
          end else if (hit) begin
            state_r <= st_result;
            if (pkt_op_i != op_load) begin
              dirty_r[pkt_index] <= 1'b1;
            end
          end else if (valid_r[pkt_index] && dirty_r[pkt_index]) begin
            state_r <= st_evict;
          end else begin
            state_r <= st_fill;
          end
        end
        st_evict: begin
          if (dma_done_i) begin
            dirty_r[pkt_index] <= 1'b0;
            state_r <= st_fill;
          end
        end
        st_fill: begin
          if (dma_done_i) begin
            valid_r[pkt_index] <= 1'b1;
            dirty_r[pkt_index] <= 1'b0;
            state_r <= st_lookup;
          end
        end
        st_result: begin
          if (result_yumi_i) begin
            state_r <= st_idle;
          end
        end
        default: state_r <= st_idle;
      endcase
    end
  end

  // arrays and result word
  always_ff @(posedge clk_i) begin
    if (pkt_yumi_o) begin
      result_r <= old_word;
      if (pkt_op_i != op_load) begin
        data_r[pkt_index][pkt_offset] <= new_word;
      end
    end
    if ((state_r == st_fill) && dma_fill_v_i) begin
      data_r[pkt_index][dma_word_idx_i] <= dma_fill_data_i;
    end
    if ((state_r == st_fill) && dma_done_i) begin
      tag_r[pkt_index] <= pkt_tag;
    end
  end

endmodule

// ==== hdl/cache_dma_wb.sv ====
// ====================
// cache DMA to Wishbone classic
// one block as 4 single-beat cycles
// ====================
`timescale 1ns/1ns

module cache_dma_wb
  import vcache_pkg::*;
(
  input clk_i
  , input rst_n_i

  , input  logic                           dma_req_v_i
  , input  logic                           dma_write_i
  , input  logic [block_addr_width_lp-1:0] dma_block_addr_i
  , output logic                           dma_done_o
  , output logic [offset_width_lp-1:0]     dma_word_idx_o
  , input  logic [data_width_lp-1:0]       dma_wdata_i
  , output logic                           dma_fill_v_o
  , output logic [data_width_lp-1:0]       dma_fill_data_o

  , output logic                           wb_cyc_o
  , output logic                           wb_stb_o
  , output logic                           wb_we_o
  , output logic [addr_width_lp-1:0]       wb_adr_o
  , output logic [data_width_lp-1:0]       wb_dat_o
  , output logic [mask_width_lp-1:0]       wb_sel_o
  , input  logic [data_width_lp-1:0]       wb_dat_i
  , input  logic                           wb_ack_i
);

  typedef enum logic [1:0] {
    st_idle,
    st_beat,
    st_gap
  } state_e;

  state_e state_r;
  logic write_r;
  logic [block_addr_width_lp-1:0] block_addr_r;
  logic [offset_width_lp-1:0] beat_r;
  logic beat_ack;
  logic last_beat;

  assign beat_ack  = (state_r == st_beat) & wb_ack_i;
  assign last_beat = (beat_r == offset_width_lp'(block_words_lp - 1));

  // bus held steady through the beat until ack
  assign wb_cyc_o = (state_r == st_beat);
  assign wb_stb_o = (state_r == st_beat);
  assign wb_we_o  = write_r;
  assign wb_adr_o = {block_addr_r, beat_r};
  assign wb_dat_o = dma_wdata_i;
  assign wb_sel_o = '1;

  assign dma_word_idx_o  = beat_r;
  assign dma_fill_v_o    = beat_ack & ~write_r;
  assign dma_fill_data_o = wb_dat_i;
  assign dma_done_o      = beat_ack & last_beat;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_r <= st_idle;
      write_r <= 1'b0;
      beat_r  <= '0;
    end else begin
      case (state_r)
        st_idle: begin
          if (dma_req_v_i) begin
            state_r <= st_beat;
            write_r <= dma_write_i;
            beat_r  <= '0;
          end
        end
        st_beat: begin
          if (wb_ack_i) begin
            if (last_beat) begin
              state_r <= st_idle;
            end else begin
              state_r <= st_gap;
              beat_r  <= beat_r + 1'b1;
            end
          end
        end
        // one idle cycle closes each classic cycle
        st_gap: state_r <= st_beat;
        default: state_r <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_r == st_idle) && dma_req_v_i) begin
      block_addr_r <= dma_block_addr_i;
    end
  end

endmodule

// ==== hdl/vcache_tile.sv ====
// ====================
// vcache tile top
// reset and coordinate registers, link, cache, DMA
// ====================
`timescale 1ns/1ns

module vcache_tile
  import vcache_pkg::*;
(
  input clk_i
  , input rst_n_i

  , input  logic [cord_width_lp-1:0]   global_x_i
  , input  logic [cord_width_lp-1:0]   global_y_i
  , output logic [cord_width_lp-1:0]   global_x_o
  , output logic [cord_width_lp-1:0]   global_y_o

  , input  logic                       req_v_i
  , output logic                       req_ready_o
  , input  cache_op_e                  req_op_i
  , input  logic [addr_width_lp-1:0]   req_addr_i
  , input  logic [data_width_lp-1:0]   req_data_i
  , input  logic [mask_width_lp-1:0]   req_mask_i
  , input  logic [tag_id_width_lp-1:0] req_id_i
  , output logic                       resp_v_o
  , input  logic                       resp_ready_i
  , output logic [data_width_lp-1:0]   resp_data_o
  , output logic [tag_id_width_lp-1:0] resp_id_o
  , output logic                       resp_store_ack_o

  , output logic                       wb_cyc_o
  , output logic                       wb_stb_o
  , output logic                       wb_we_o
  , output logic [addr_width_lp-1:0]   wb_adr_o
  , output logic [data_width_lp-1:0]   wb_dat_o
  , output logic [mask_width_lp-1:0]   wb_sel_o
  , input  logic [data_width_lp-1:0]   wb_dat_i
  , input  logic                       wb_ack_i
);

  logic rst_n_r;
  logic [cord_width_lp-1:0] global_x_r;
  logic [cord_width_lp-1:0] global_y_r;

  // reset and coordinates each take one flop
  always_ff @(posedge clk_i) begin
    rst_n_r    <= rst_n_i;
    global_x_r <= global_x_i;
    global_y_r <= global_y_i;
  end

  assign global_x_o = global_x_r;
  // next tile down the column
  assign global_y_o = cord_width_lp'(global_y_r + 1'b1);

  logic pkt_v;
  logic pkt_yumi;
  cache_op_e pkt_op;
  logic [addr_width_lp-1:0] pkt_addr;
  logic [data_width_lp-1:0] pkt_data;
  logic [mask_width_lp-1:0] pkt_mask;
  logic result_v;
  logic [data_width_lp-1:0] result_data;
  logic result_yumi;

  logic dma_req_v;
  logic dma_write;
  logic [block_addr_width_lp-1:0] dma_block_addr;
  logic dma_done;
  logic [offset_width_lp-1:0] dma_word_idx;
  logic [data_width_lp-1:0] dma_wdata;
  logic dma_fill_v;
  logic [data_width_lp-1:0] dma_fill_data;

  // core port signals share names with the top ports
  link_to_cache link (
    .rst_n_i(rst_n_r)
    ,.pkt_v_o(pkt_v)
    ,.pkt_yumi_i(pkt_yumi)
    ,.pkt_op_o(pkt_op)
    ,.pkt_addr_o(pkt_addr)
    ,.pkt_data_o(pkt_data)
    ,.pkt_mask_o(pkt_mask)
    ,.result_v_i(result_v)
    ,.result_data_i(result_data)
    ,.result_yumi_o(result_yumi)
    ,.*
  );

  vcache_core cache (
    .clk_i(clk_i)
    ,.rst_n_i(rst_n_r)
    ,.pkt_v_i(pkt_v)
    ,.pkt_yumi_o(pkt_yumi)
    ,.pkt_op_i(pkt_op)
    ,.pkt_addr_i(pkt_addr)
    ,.pkt_data_i(pkt_data)
    ,.pkt_mask_i(pkt_mask)
    ,.result_v_o(result_v)
    ,.result_data_o(result_data)
    ,.result_yumi_i(result_yumi)
    ,.dma_req_v_o(dma_req_v)
    ,.dma_write_o(dma_write)
    ,.dma_block_addr_o(dma_block_addr)
    ,.dma_done_i(dma_done)
    ,.dma_word_idx_i(dma_word_idx)
    ,.dma_wdata_o(dma_wdata)
    ,.dma_fill_v_i(dma_fill_v)
    ,.dma_fill_data_i(dma_fill_data)
  );

  // Wishbone ports connect by name
  cache_dma_wb dma (
    .rst_n_i(rst_n_r)
    ,.dma_req_v_i(dma_req_v)
    ,.dma_write_i(dma_write)
    ,.dma_block_addr_i(dma_block_addr)
    ,.dma_done_o(dma_done)
    ,.dma_word_idx_o(dma_word_idx)
    ,.dma_wdata_i(dma_wdata)
    ,.dma_fill_v_o(dma_fill_v)
    ,.dma_fill_data_o(dma_fill_data)
    ,.*
  );

endmodule

// ==== testbench/tb_clock_gen.sv ====
// ====================
// testbench clock and reset
// ====================
`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int period_p = 10
  , parameter int reset_cycles_p = 4
) (
  output logic clk_o
  , output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(period_p / 2) clk_o = ~clk_o;
  end

  // release on a falling edge, clear of the sampling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (reset_cycles_p) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

// ==== testbench/wb_mem_model.sv ====
// ====================
// Wishbone classic slave memory
// patterned contents, random ack delay
// ====================
`timescale 1ns/1ns

module wb_mem_model
  import vcache_pkg::*;
(
  input clk_i
  , input rst_n_i

  , input  logic                     cyc_i
  , input  logic                     stb_i
  , input  logic                     we_i
  , input  logic [addr_width_lp-1:0] adr_i
  , input  logic [data_width_lp-1:0] dat_i
  , input  logic [mask_width_lp-1:0] sel_i
  , output logic [data_width_lp-1:0] dat_o
  , output logic                     ack_o
);

  logic [data_width_lp-1:0] mem_r [1 << addr_width_lp];
  logic [data_width_lp-1:0] wr_word;
  logic [1:0] delay_r;
  logic busy_r;

  // every word starts as its address xor a fixed pattern
  initial begin
    for (int a = 0; a < (1 << addr_width_lp); a++) begin
      mem_r[a] = 32'(a) ^ 32'hA5A5_0000;
    end
  end

  always_comb begin
    wr_word = mem_r[adr_i];
    for (int b = 0; b < mask_width_lp; b++) begin
      if (sel_i[b]) begin
        wr_word[8*b +: 8] = dat_i[8*b +: 8];
      end
    end
  end

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      ack_o   <= 1'b0;
      busy_r  <= 1'b0;
      delay_r <= 2'd0;
      dat_o   <= '0;
    end else begin
      ack_o <= 1'b0;
      if (cyc_i && stb_i && !ack_o) begin
        if (!busy_r) begin
          busy_r  <= 1'b1;
          delay_r <= 2'($urandom % 4);
        end else if (delay_r != 2'd0) begin
          delay_r <= delay_r - 2'd1;
        end else begin
          busy_r <= 1'b0;
          ack_o  <= 1'b1;
          if (we_i) begin
            mem_r[adr_i] <= wr_word;
          end else begin
            dat_o <= mem_r[adr_i];
          end
        end
      end
    end
  end

endmodule

// ==== testbench/tb_vcache_tile.sv ====
// ====================
// vcache tile testbench
// directed tests against a word-array reference model
// ====================
`timescale 1ns/1ns

module tb_vcache_tile
  import vcache_pkg::*;
();

  localparam int timeout_cycles_lp = 2000;

  logic clk;
  logic rst_n;
  logic [cord_width_lp-1:0] gx_in;
  logic [cord_width_lp-1:0] gy_in;
  logic [cord_width_lp-1:0] gx_out;
  logic [cord_width_lp-1:0] gy_out;
  logic req_v;
  logic req_ready;
  cache_op_e req_op;
  logic [addr_width_lp-1:0] req_addr;
  logic [data_width_lp-1:0] req_data;
  logic [mask_width_lp-1:0] req_mask;
  logic [tag_id_width_lp-1:0] req_id;
  logic resp_v;
  logic resp_ready;
  logic [data_width_lp-1:0] resp_data;
  logic [tag_id_width_lp-1:0] resp_id;
  logic resp_store_ack;
  logic wb_cyc;
  logic wb_stb;
  logic wb_we;
  logic [addr_width_lp-1:0] wb_adr;
  logic [data_width_lp-1:0] wb_dat_w;
  logic [mask_width_lp-1:0] wb_sel;
  logic [data_width_lp-1:0] wb_dat_r;
  logic wb_ack;

  int errors;
  int checks;
  logic [tag_id_width_lp-1:0] next_id;
  logic [data_width_lp-1:0] model_mem [1 << addr_width_lp];

  // expected responses, in request order
  logic [data_width_lp-1:0] exp_data_q[$];
  logic [tag_id_width_lp-1:0] exp_id_q[$];
  logic exp_ack_q[$];
  string exp_name_q[$];

  tb_clock_gen clk_gen (
    .clk_o(clk)
    ,.rst_n_o(rst_n)
  );

  wb_mem_model mem (
    .clk_i(clk)
    ,.rst_n_i(rst_n)
    ,.cyc_i(wb_cyc)
    ,.stb_i(wb_stb)
    ,.we_i(wb_we)
    ,.adr_i(wb_adr)
    ,.dat_i(wb_dat_w)
    ,.sel_i(wb_sel)
    ,.dat_o(wb_dat_r)
    ,.ack_o(wb_ack)
  );

  vcache_tile dut0 (
    .clk_i(clk)
    ,.rst_n_i(rst_n)
    ,.global_x_i(gx_in)
    ,.global_y_i(gy_in)
    ,.global_x_o(gx_out)
    ,.global_y_o(gy_out)
    ,.req_v_i(req_v)
    ,.req_ready_o(req_ready)
    ,.req_op_i(req_op)
    ,.req_addr_i(req_addr)
    ,.req_data_i(req_data)
    ,.req_mask_i(req_mask)
    ,.req_id_i(req_id)
    ,.resp_v_o(resp_v)
    ,.resp_ready_i(resp_ready)
    ,.resp_data_o(resp_data)
    ,.resp_id_o(resp_id)
    ,.resp_store_ack_o(resp_store_ack)
    ,.wb_cyc_o(wb_cyc)
    ,.wb_stb_o(wb_stb)
    ,.wb_we_o(wb_we)
    ,.wb_adr_o(wb_adr)
    ,.wb_dat_o(wb_dat_w)
    ,.wb_sel_o(wb_sel)
    ,.wb_dat_i(wb_dat_r)
    ,.wb_ack_i(wb_ack)
  );

  function automatic logic [31:0] init_word(input logic [addr_width_lp-1:0] a);
    return {20'h0, a} ^ 32'hA5A5_0000;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_data,
                                              input logic [3:0] mask);
    logic [31:0] w;
    w = old_word;
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) begin
        w[8*b +: 8] = new_data[8*b +: 8];
      end
    end
    return w;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    checks++;
    assert (exp == got) else begin
      $display("error %s: expected %h, actual %h", name, exp, got);
      errors++;
    end
  endtask

  // applies one request to the reference words
  task automatic model_apply(input cache_op_e op, input logic [addr_width_lp-1:0] addr,
                             input logic [31:0] data, input logic [3:0] mask,
                             output logic [31:0] exp_data, output logic exp_ack);
    logic [31:0] old_word;
    old_word = model_mem[addr];
    exp_data = old_word;
    exp_ack  = 1'b0;
    if (op == op_store) begin
      model_mem[addr] = merge_bytes(old_word, data, mask);
      exp_data = '0;
      exp_ack  = 1'b1;
    end else if (op == op_amo_add) begin
      model_mem[addr] = old_word + data;
    end
  endtask

  task automatic send_req(input string name, input cache_op_e op,
                          input logic [addr_width_lp-1:0] addr,
                          input logic [31:0] data, input logic [3:0] mask);
    int cnt;
    logic accepted;
    logic [31:0] exp_data;
    logic exp_ack;
    cnt = 0;
    accepted = 1'b0;
    model_apply(op, addr, data, mask, exp_data, exp_ack);
    exp_data_q.push_back(exp_data);
    exp_ack_q.push_back(exp_ack);
    exp_id_q.push_back(next_id);
    exp_name_q.push_back(name);
    @(negedge clk);
    req_v    = 1'b1;
    req_op   = op;
    req_addr = addr;
    req_data = data;
    req_mask = mask;
    req_id   = next_id;
    // ready seen mid-cycle means the next rising edge takes it
    while (!accepted && cnt < timeout_cycles_lp) begin
      accepted = req_ready;
      @(negedge clk);
      cnt++;
    end
    req_v   = 1'b0;
    next_id = next_id + 4'd1;
    assert (accepted) else begin
      $display("request %s was never accepted by the tile", name);
      errors++;
    end
  endtask

  task automatic check_resp();
    string name;
    if (exp_name_q.size() == 0) begin
      $display("a response came back with no request outstanding");
      errors++;
    end else begin
      name = exp_name_q.pop_front();
      check_value({name, " data"}, exp_data_q.pop_front(), resp_data);
      check_value({name, " id"}, {28'h0, exp_id_q.pop_front()}, {28'h0, resp_id});
      check_value({name, " store ack"}, {31'h0, exp_ack_q.pop_front()},
                  {31'h0, resp_store_ack});
    end
  endtask

  task automatic recv_resp();
    int cnt;
    logic got;
    cnt = 0;
    got = 1'b0;
    @(negedge clk);
    resp_ready = 1'b1;
    while (!got && cnt < timeout_cycles_lp) begin
      if (resp_v) begin
        got = 1'b1;
        check_resp();
      end
      @(negedge clk);
      cnt++;
    end
    resp_ready = 1'b0;
    assert (got) else begin
      $display("no response arrived before the timeout");
      errors++;
    end
  endtask

  // takes n responses while ready toggles at random
  task automatic drain_random(input int n);
    int cnt;
    int received;
    cnt = 0;
    received = 0;
    while (received < n && cnt < n * 300) begin
      @(negedge clk);
      resp_ready = 1'($urandom);
      if (resp_v && resp_ready) begin
        check_resp();
        received++;
      end
      cnt++;
    end
    @(negedge clk);
    resp_ready = 1'b0;
    assert (received == n) else begin
      $display("only %0d of %0d responses arrived before the timeout", received, n);
      errors++;
    end
  endtask

  task automatic wait_ready();
    int cnt;
    cnt = 0;
    while (!rst_n && cnt < timeout_cycles_lp) begin
      @(negedge clk);
      cnt++;
    end
    cnt = 0;
    while (!req_ready && cnt < timeout_cycles_lp) begin
      @(negedge clk);
      cnt++;
    end
    assert (req_ready) else begin
      $display("the tile never became ready after reset");
      errors++;
    end
    check_value("reset resp_v", 32'h0, {31'h0, resp_v});
    check_value("reset wb_cyc", 32'h0, {31'h0, wb_cyc});
    check_value("reset wb_stb", 32'h0, {31'h0, wb_stb});
  endtask

  task automatic test_coords();
    logic [3:0] xs [3];
    logic [3:0] ys [3];
    xs = '{4'h3, 4'hA, 4'h0};
    ys = '{4'h7, 4'hF, 4'h0};
    for (int i = 0; i < 3; i++) begin
      @(negedge clk);
      gx_in = xs[i];
      gy_in = ys[i];
      @(negedge clk);
      check_value("test_coords x", {28'h0, xs[i]}, {28'h0, gx_out});
      // y wraps within the coordinate width
      check_value("test_coords y", {28'h0, 4'(ys[i] + 4'd1)}, {28'h0, gy_out});
    end
  endtask

  task automatic test_fill_load();
    logic [addr_width_lp-1:0] addrs [4];
    addrs = '{12'h100, 12'h105, 12'h2A7, 12'hFFC};
    for (int i = 0; i < 4; i++) begin
      send_req("test_fill_load", op_load, addrs[i], 32'h0, 4'h0);
      recv_resp();
    end
  endtask

  task automatic test_store_load_mask();
    send_req("test_store_load_mask", op_store, 12'h020, 32'h1122_3344, 4'b0101);
    recv_resp();
    send_req("test_store_load_mask", op_load, 12'h020, 32'h0, 4'h0);
    recv_resp();
    send_req("test_store_load_mask", op_store, 12'h021, 32'hDEAD_BEEF, 4'b1111);
    recv_resp();
    send_req("test_store_load_mask", op_store, 12'h7C3, 32'hCAFE_F00D, 4'b1000);
    recv_resp();
    send_req("test_store_load_mask", op_load, 12'h021, 32'h0, 4'h0);
    recv_resp();
    send_req("test_store_load_mask", op_load, 12'h7C3, 32'h0, 4'h0);
    recv_resp();
  endtask

  // set 5 with tags 1, 2 and 3
  task automatic test_evict();
    send_req("test_evict", op_store, 12'h056, 32'h5A5A_1234, 4'b1111);
    recv_resp();
    send_req("test_evict", op_load, 12'h094, 32'h0, 4'h0);
    recv_resp();
    send_req("test_evict", op_load, 12'h0D5, 32'h0, 4'h0);
    recv_resp();
    send_req("test_evict", op_load, 12'h056, 32'h0, 4'h0);
    recv_resp();
  endtask

  task automatic test_amo_add();
    send_req("test_amo_add", op_amo_add, 12'h333, 32'h1000_0001, 4'b1111);
    recv_resp();
    send_req("test_amo_add", op_load, 12'h333, 32'h0, 4'h0);
    recv_resp();
    send_req("test_amo_add", op_amo_add, 12'h333, 32'hFFFF_FFFF, 4'b1111);
    recv_resp();
    send_req("test_amo_add", op_load, 12'h333, 32'h0, 4'h0);
    recv_resp();
  endtask

  task automatic test_backpressure(input int n);
    fork
      begin
        for (int i = 0; i < n; i++) begin
          // few tags and sets, so hits, fills and evictions all occur
          send_req("test_backpressure", cache_op_e'(2'($urandom % 3)),
                   {6'($urandom % 4), 4'($urandom % 4), 2'($urandom)},
                   $urandom, 4'($urandom));
        end
      end
      drain_random(n);
    join
  endtask

  initial begin
    void'($urandom(72565));
    errors     = 0;
    checks     = 0;
    next_id    = '0;
    gx_in      = '0;
    gy_in      = '0;
    req_v      = 1'b0;
    req_op     = op_load;
    req_addr   = '0;
    req_data   = '0;
    req_mask   = '0;
    req_id     = '0;
    resp_ready = 1'b0;
    for (int a = 0; a < (1 << addr_width_lp); a++) begin
      model_mem[a] = init_word(12'(a));
    end

    wait_ready();
    test_coords();
    test_fill_load();
    test_store_load_mask();
    test_evict();
    test_amo_add();
    test_backpressure(24);

    assert (exp_name_q.size() == 0) else begin
      $display("%0d responses never came back", exp_name_q.size());
      errors++;
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== list.f ====
hdl/vcache_pkg.sv
hdl/vcache_fifo.sv
hdl/link_to_cache.sv
hdl/vcache_core.sv
hdl/cache_dma_wb.sv
hdl/vcache_tile.sv
testbench/tb_clock_gen.sv
testbench/wb_mem_model.sv
testbench/tb_vcache_tile.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the vcache tile testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  --top-module tb_vcache_tile \
  -f list.f \
  -o sim_tb_vcache_tile

./obj_dir/sim_tb_vcache_tile | tee sim.log

if grep -q ">>> FAIL" sim.log; then
  echo "simulation reported failures, see sim.log"
  exit 1
fi

echo "simulation finished without failures"
